/* hdl/arb_cfg_if.sv */
`timescale 1ns/100ps

// config out of the register block, status back from the core
interface arb_cfg_if;
   import arb_pkg::*;

   ////////////////////
   // regs -> core
   ////////////////////
   logic      enable;      // ctrl bit 0
   arb_req_t  mask;        // 1 = requester blocked
   arb_hold_t hold_limit;  // extra cycles an owner may keep the grant

   ////////////////////
   // core -> regs
   ////////////////////
   arb_req_t  gnt;         // registered one-hot grant, zero when idle
   logic      handoff;     // one cycle pulse per new owner

   modport regs
   (
      output enable, mask, hold_limit,
      input  gnt, handoff
   );

   modport core
   (
      input  enable, mask, hold_limit,
      output gnt, handoff
   );

endinterface

/* hdl/arb_pkg.sv */
`include "arb_defines.svh"

package arb_pkg;

   ////////////////////
   // vector types
   ////////////////////

   // one bit per requester, bit i is requester i
   typedef logic [`ARB_NUM_REQ-1:0] arb_req_t;   // req, mask and gnt

   // hold limit and the running hold count
   typedef logic [`ARB_HOLD_W-1:0] arb_hold_t;

   ////////////////////
   // register map
   ////////////////////

   typedef enum logic [7:0]
   {
      REG_CTRL = `ARB_ADDR_CTRL,   // bit 0 enable
      REG_MASK = `ARB_ADDR_MASK,   // 1 blocks requester
      REG_HOLD = `ARB_ADDR_HOLD,   // hold limit
      REG_STAT = `ARB_ADDR_STAT,   // current grant, ro
      REG_CNT  = `ARB_ADDR_CNT     // handoff count, ro
   } arb_reg_e;

endpackage

/* hdl/arb_regs.sv */
`timescale 1ns/100ps
`include "arb_defines.svh"

module arb_regs
(
   input  logic        clk,
   input  logic        rst,
   input  logic [7:0]  paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   arb_cfg_if.regs     cfg
);
   import arb_pkg::*;

   localparam int CNT_W = 16;   // handoff counter width, wraps

   arb_reg_e   reg_sel;     // decoded offset
   logic       access;      // apb access phase
   logic       wr_en;
   logic       addr_ok;     // one of the five registers
   logic       ro_hit;      // stat or cnt
   logic [31:0] rd_data;

   logic       enable_q;
   arb_req_t   mask_q;
   arb_hold_t  hold_q;
   logic [CNT_W-1:0] cnt_q;

   assign reg_sel = arb_reg_e'(paddr);
   assign access  = psel & penable;
   assign wr_en   = access & pwrite;

   ////////////////////
   // address decode / read mux
   ////////////////////
   always_comb
   begin
      rd_data = '0;
      addr_ok = 1'b1;
      ro_hit  = 1'b0;
      case (reg_sel)
         REG_CTRL: rd_data[0] = enable_q;
         REG_MASK: rd_data[`ARB_NUM_REQ-1:0] = mask_q;
         REG_HOLD: rd_data[`ARB_HOLD_W-1:0] = hold_q;
         REG_STAT:
         begin
            rd_data[`ARB_NUM_REQ-1:0] = cfg.gnt;   // live grant
            ro_hit = 1'b1;
         end
         REG_CNT:
         begin
            rd_data[CNT_W-1:0] = cnt_q;
            ro_hit = 1'b1;
         end
         default: addr_ok = 1'b0;   // hole in the map
      endcase
   end

   assign prdata  = rd_data;   // sampled by master in access phase
   assign pready  = 1'b1;      // no wait states
   assign pslverr = access & (~addr_ok | (pwrite & ro_hit));

   ////////////////////
   // rw registers
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         enable_q <= 1'b0;
         mask_q   <= '0;
         hold_q   <= arb_hold_t'(`ARB_HOLD_RST);
      end
      else if (wr_en && addr_ok && !ro_hit)   // bad writes dropped
      begin
         case (reg_sel)
            REG_CTRL: enable_q <= pwdata[0];
            REG_MASK: mask_q   <= pwdata[`ARB_NUM_REQ-1:0];
            REG_HOLD: hold_q   <= pwdata[`ARB_HOLD_W-1:0];
            default:  enable_q <= enable_q;
         endcase
      end
   end

   // counts every new owner, idle -> owner included
   always_ff @(posedge clk)
   begin
      if (rst)
         cnt_q <= '0;
      else if (cfg.handoff)
         cnt_q <= cnt_q + 1'b1;   // wraps at max
   end

   assign cfg.enable     = enable_q;
   assign cfg.mask       = mask_q;
   assign cfg.hold_limit = hold_q;

   ////////////////////
   // checks
   ////////////////////

   // error only in an access phase that followed a setup phase
   a_slverr_access: assert property (@(posedge clk) disable iff (rst)
      pslverr |-> (psel && penable && $past(psel && !penable)));

endmodule

/* hdl/arb_top.sv */
`timescale 1ns/100ps

module arb_top
(
   input  logic              clk,
   input  logic              rst,
   // apb slave
   input  logic [7:0]        paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   // requesters
   input  arb_pkg::arb_req_t req,
   output arb_pkg::arb_req_t gnt
);

   // config and status between the two blocks
   arb_cfg_if cfg_i ();

   ////////////////////
   // register block
   ////////////////////
   arb_regs regs_i
   (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg_i.regs)
   );

   ////////////////////
   // arbiter core
   ////////////////////
   rr_arbiter arb_i
   (
      .clk (clk),
      .rst (rst),
      .req (req),
      .cfg (cfg_i.core)
   );

   assign gnt = cfg_i.gnt;   // registered in the core

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/100ps
`include "arb_defines.svh"

module rr_arbiter
(
   input  logic             clk,
   input  logic             rst,
   input  arb_pkg::arb_req_t req,
   arb_cfg_if.core          cfg
);
   import arb_pkg::*;

   arb_req_t  gnt_q;       // one-hot owner, all zero = idle
   arb_hold_t hold_cnt;    // extra cycles owned so far
   logic      handoff_q;

   arb_req_t  req_m;       // masked requests
   arb_req_t  cand;        // waiting requesters other than owner
   arb_req_t  pick;        // next in rotation
   logic      owner_req;   // owner still asking
   logic      at_limit;
   int        owner_idx;

   arb_req_t  gnt_d;
   arb_hold_t cnt_d;

   // first set bit of cand after start, wrapping 4 -> 0
   function automatic arb_req_t rr_pick(int start, arb_req_t vec);
      arb_req_t sel;
      int       idx;
      sel = '0;
      for (int k = `ARB_NUM_REQ; k >= 1; k--)   // nearest offset wins
      begin
         idx = (start + k) % `ARB_NUM_REQ;
         if (vec[idx])
         begin
            sel      = '0;
            sel[idx] = 1'b1;
         end
      end
      return sel;
   endfunction

   assign req_m     = req & ~cfg.mask;     // mask applies at once
   assign cand      = req_m & ~gnt_q;
   assign owner_req = |(gnt_q & req_m);
   assign at_limit  = hold_cnt >= cfg.hold_limit;   // >= covers a lowered limit

   // index of current owner
   always_comb
   begin
      owner_idx = `ARB_NUM_REQ - 1;   // idle, so search begins at 0
      for (int i = 0; i < `ARB_NUM_REQ; i++)
      begin
         if (gnt_q[i])
            owner_idx = i;
      end
   end

   assign pick = rr_pick(owner_idx, cand);

   ////////////////////
   // next grant
   ////////////////////
   always_comb
   begin
      gnt_d = gnt_q;
      cnt_d = '0;
      if (!cfg.enable)
         gnt_d = '0;                  // forced idle
      else if (owner_req)
      begin
         if (at_limit && (pick != '0))
            gnt_d = pick;             // hold used up, someone waiting
         else if (at_limit)
            cnt_d = cfg.hold_limit;   // nobody waiting, stay parked
         else
            cnt_d = hold_cnt + arb_hold_t'(1);
      end
      else
         gnt_d = pick;                // dropped or idle, may be zero
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         gnt_q     <= '0;
         hold_cnt  <= '0;
         handoff_q <= 1'b0;
      end
      else
      begin
         gnt_q     <= gnt_d;
         hold_cnt  <= cnt_d;
         handoff_q <= (gnt_d != '0) && (gnt_d != gnt_q);   // new owner only
      end
   end

   assign cfg.gnt     = gnt_q;
   assign cfg.handoff = handoff_q;

   ////////////////////
   // checks
   ////////////////////

   a_gnt_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(gnt_q));

   // counter bounded by limit, except the cycle after the limit is rewritten
   a_hold_bound: assert property (@(posedge clk) disable iff (rst)
      ((gnt_q != '0) && $stable(cfg.hold_limit)) |-> (hold_cnt <= cfg.hold_limit));

endmodule

/* include/arb_defines.svh */
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// requester count and hold counter sizing
`define ARB_NUM_REQ   5
`define ARB_HOLD_W    3
`define ARB_HOLD_RST  4      // owner gets four extra cycles after reset

// apb register offsets
`define ARB_ADDR_CTRL 8'h00
`define ARB_ADDR_MASK 8'h04
`define ARB_ADDR_HOLD 8'h08
`define ARB_ADDR_STAT 8'h0C
`define ARB_ADDR_CNT  8'h10

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the arbiter testbench with verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module arb_tb -Mdir "$OBJ" -o arb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/arb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides pass or fail
if grep -qx "all tests passed" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

/* sources.f */
+incdir+include
hdl/arb_pkg.sv
hdl/arb_cfg_if.sv
hdl/arb_regs.sv
hdl/rr_arbiter.sv
hdl/arb_top.sv
tb/arb_tb.sv

/* tb/arb_cases.txt */
# columns: op, then three hex fields
# W addr wdata slverr | R addr rdata slverr | Q req cycles gnt
# reset values, arbiter disabled
R 00 00000000 0
R 04 00000000 0
R 08 00000004 0
R 0c 00000000 0
R 10 00000000 0
Q 1f 2 00
# single requester kept past the hold limit
Q 00 1 00
W 00 00000001 0
Q 04 1 04
Q 04 6 04
Q 00 1 00
# hold limit 1, full rotation
W 08 00000001 0
Q 1f 1 01
Q 1f 1 01
Q 1f 1 02
Q 1f 1 02
Q 1f 1 04
Q 1f 1 04
Q 1f 1 08
Q 1f 1 08
Q 1f 1 10
Q 1f 1 10
Q 1f 1 01
Q 1f 1 01
# owner drops, gaps skipped, wrap to 0
Q 14 1 04
Q 10 1 10
Q 01 1 01
Q 00 1 00
# requester 0 masked, then enable cleared
W 04 00000001 0
Q 1f 1 02
Q 1f 1 02
Q 1f 1 04
Q 1f 1 04
Q 1f 1 08
Q 1f 1 08
Q 1f 1 10
Q 1f 1 10
Q 1f 1 02
Q 01 2 00
Q 1f 1 02
W 00 00000000 0
Q 1f 0 04
Q 1f 1 00
Q 1f 3 00
# status, handoff count and errors
W 00 00000001 0
Q 08 1 08
R 0c 00000008 0
R 10 00000012 0
R 14 00000000 1
W 0c 0000001f 1
W 10 0000ffff 1
R 00 00000001 0
R 04 00000001 0
R 08 00000001 0
R 0c 00000008 0
R 10 00000012 0
Q 00 1 00

/* tb/arb_tb.sv */
`timescale 1ns/100ps
`include "arb_defines.svh"

module arb_tb;

   localparam int MAX_WAIT = 16;   // edges allowed for pready
   localparam int MAX_CYC  = 64;   // longest Q wait accepted

   logic        clk;
   logic        rst;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [`ARB_NUM_REQ-1:0] req;
   logic [`ARB_NUM_REQ-1:0] gnt;

   int n_pass;
   int n_fail;
   int errs;   // failed checks in the current case

   arb_top dut_i
   (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .req     (req),
      .gnt     (gnt)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // bus tasks
   ////////////////////

   // one apb transfer, entered and left 1 ns after an edge
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int waits;
      waits   = 0;
      paddr   = addr;   // setup phase
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1 penable = 1'b1;   // access phase
      #1;
      while (!pready && waits < MAX_WAIT)
      begin
         @(posedge clk);
         #2;
         waits++;
      end
      if (!pready)
      begin
         $display("no pready from the DUT within %0d cycles at address %h", MAX_WAIT, addr);
         errs++;
      end
      rdata = prdata;   // mid access cycle, stable
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // drive req, let some edges pass, compare gnt
   task automatic grant_after(input logic [`ARB_NUM_REQ-1:0] r, input int cycles,
                              input logic [`ARB_NUM_REQ-1:0] exp);
      int n;
      n   = 0;
      req = r;
      if (cycles > MAX_CYC)
      begin
         $display("wait of %0d cycles is longer than the %0d cycle limit", cycles, MAX_CYC);
         errs++;
      end
      while (n < cycles && n < MAX_CYC)
      begin
         @(posedge clk);
         #1;   // gnt settled after the edge
         n++;
      end
      if (gnt !== exp)
      begin
         $display("ERR gnt expected %h got %h", exp, gnt);
         errs++;
      end
   endtask

   ////////////////////
   // case replay
   ////////////////////
   initial
   begin
      int          fd;
      int          nf;
      int          case_no;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] rdata;
      logic        err;

      rst     = 1'b1;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      req     = '0;
      n_pass  = 0;
      n_fail  = 0;
      case_no = 0;
      repeat (3) @(posedge clk);   // 3 cycles of reset
      #1 rst = 1'b0;

      fd = $fopen("tb/arb_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the case file tb/arb_cases.txt");
         $display("tests failed");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;   // blank or column notes
            case_no++;
            errs = 0;
            op   = line.getc(0);
            nf   = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            if (nf != 3)
            begin
               $display("case %0d has a malformed line", case_no);
               errs++;
            end
            else if (op == "W")
            begin
               apb_xfer(1'b1, a[7:0], b, rdata, err);
               if (err !== c[0])
               begin
                  $display("ERR pslverr expected %h got %h", c[0], err);
                  errs++;
               end
            end
            else if (op == "R")
            begin
               apb_xfer(1'b0, a[7:0], 32'h0, rdata, err);
               if (rdata !== b)
               begin
                  $display("ERR prdata expected %h got %h", b, rdata);
                  errs++;
               end
               if (err !== c[0])
               begin
                  $display("ERR pslverr expected %h got %h", c[0], err);
                  errs++;
               end
            end
            else if (op == "Q")
               grant_after(a[`ARB_NUM_REQ-1:0], int'(b), c[`ARB_NUM_REQ-1:0]);
            else
            begin
               $display("case %0d has an unknown operation %c", case_no, op);
               errs++;
            end

            if (errs == 0)
               n_pass++;
            else
               n_fail++;
            $display("case %0d %c: %s", case_no, op, (errs == 0) ? "ok" : "FAIL");
         end
         $fclose(fd);

         $display("%0d cases run, %0d ok, %0d bad", case_no, n_pass, n_fail);
         if (n_fail == 0 && n_pass > 0)
            $display("all tests passed");
         else
            $display("tests failed");
         $finish;
      end
   end

endmodule
